// File: hw/icache_pkg.sv
////////////////////////////////////////////////////////////
// icache shared types
// 16-bit byte address, 16-byte blocks, 64 direct-mapped lines
////////////////////////////////////////////////////////////
package icache_pkg;

  // address layout  | tag 6 | index 6 | offset 4 |
  typedef logic [15:0]  addr_t;
  typedef logic [5:0]   tag_t;
  typedef logic [5:0]   index_t;
  typedef logic [3:0]   offset_t;
  typedef logic [11:0]  blk_addr_t;  // tag and index together
  typedef logic [127:0] block_t;
  typedef logic [31:0]  instr_t;

  localparam int NUM_LINES = 64;
  localparam int NUM_BLKS  = 4096;   // 64 KB backing memory

  // highest offset whose four bytes stay inside one block
  localparam offset_t LAST_IN_BLK_OFF = 4'd12;

  // decoded fetch address
  typedef struct packed {
    tag_t    tag;
    index_t  index;
    offset_t offset;
  } fetch_addr_t;

  // refill response, ready is a one-cycle pulse
  typedef struct packed {
    logic   ready;
    block_t data;
  } mem_rsp_t;

  // memory image
  // byte at address a holds a[7:0] ^ a[15:8]
  // blocks are little-endian, offset k sits at bits 8k+7:8k

  typedef enum logic [2:0] {
    IDLE,
    FILL_REQ,
    FILL_WAIT,
    FILL_WR,
    ALIGN_CHK
  } ctrl_state_t;

endpackage

// File: hw/icache_refill_mem.sv
////////////////////////////////////////////////////////////
// icache refill memory
// behavioral block store, answers one read after MEM_LAT cycles
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module icache_refill_mem #(
  parameter int MEM_LAT = 4
) (
  input  logic                  i_riscv_icache_clk,
  input  logic                  i_rst_n,
  input  logic                  i_rd,
  input  icache_pkg::blk_addr_t i_blk_addr,
  output icache_pkg::mem_rsp_t  o_rsp
);

  import icache_pkg::*;

  localparam int CNT_W = (MEM_LAT > 1) ? $clog2(MEM_LAT) : 1;

  block_t     image [NUM_BLKS];
  blk_addr_t  addr_q;           // block under service
  logic       pending;
  logic [CNT_W-1:0] cnt;        // cycles left until ready

  // fixed pattern image
  initial begin
    addr_t a;
    for (int b = 0; b < NUM_BLKS; b++) begin
      for (int k = 0; k < 16; k++) begin
        a = addr_t'(b * 16 + k);
        image[b][8*k +: 8] = a[7:0] ^ a[15:8];
      end
    end
  end

  always_ff @(posedge i_riscv_icache_clk) begin
    if (!i_rst_n) begin
      pending <= 1'b0;
      cnt     <= '0;
    end else if (i_rd) begin
      pending <= 1'b1;
      cnt     <= CNT_W'(MEM_LAT - 1);
    end else if (pending) begin
      if (cnt == '0) pending <= 1'b0;   // ready cycle ends the request
      else           cnt     <= cnt - 1'b1;
    end
  end

  always_ff @(posedge i_riscv_icache_clk) begin
    if (i_rd) addr_q <= i_blk_addr;
  end

  // data stays on the bus after the ready pulse until the next read
  assign o_rsp = '{ready: pending && (cnt == '0), data: image[addr_q]};

  // the controller keeps a single request in flight
  a_one_req : assert property (@(posedge i_riscv_icache_clk) disable iff (!i_rst_n)
    i_rd |-> !pending);

endmodule

// File: hw/icache_tag_array.sv
////////////////////////////////////////////////////////////
// icache tag array
// 64 tags plus valid bits, hit lookup for current and next block
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module icache_tag_array (
  input  logic               i_riscv_icache_clk,
  input  logic               i_rst_n,
  input  icache_pkg::tag_t   i_tag,
  input  icache_pkg::index_t i_index,
  input  icache_pkg::tag_t   i_tag_next,
  input  icache_pkg::index_t i_index_next,
  input  logic               i_wr,
  input  logic               i_wr_sel,      // 1 writes the next block's line
  output logic               o_hit,
  output logic               o_hit_next
);

  import icache_pkg::*;

  tag_t                 tags [NUM_LINES];
  logic [NUM_LINES-1:0] valid;

  tag_t   wr_tag;
  index_t wr_index;

  assign wr_tag   = i_wr_sel ? i_tag_next   : i_tag;
  assign wr_index = i_wr_sel ? i_index_next : i_index;

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_riscv_icache_clk) begin
    if (!i_rst_n) begin
      valid <= '0;
    end else if (i_wr) begin
      valid[wr_index] <= 1'b1;
    end
  end

  always_ff @(posedge i_riscv_icache_clk) begin
    if (i_wr) tags[wr_index] <= wr_tag;
  end

  ////////////////////////////////////////////////////////////
  // lookup
  ////////////////////////////////////////////////////////////

  assign o_hit      = valid[i_index]      && (tags[i_index] == i_tag);
  assign o_hit_next = valid[i_index_next] && (tags[i_index_next] == i_tag_next);

endmodule

// File: hw/icache_data_array.sv
////////////////////////////////////////////////////////////
// icache data array
// 64 blocks, two async read ports, one refill write port
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module icache_data_array (
  input  logic               i_riscv_icache_clk,
  input  icache_pkg::index_t i_index,
  input  icache_pkg::index_t i_index_next,
  input  logic               i_wr,
  input  logic               i_wr_sel,
  input  icache_pkg::block_t i_wdata,
  output icache_pkg::block_t o_blk,
  output icache_pkg::block_t o_blk_next
);

  import icache_pkg::*;

  block_t blocks [NUM_LINES];
  index_t wr_index;

  // refill goes to the current or the following line
  assign wr_index = i_wr_sel ? i_index_next : i_index;

  always_ff @(posedge i_riscv_icache_clk) begin
    if (i_wr) blocks[wr_index] <= i_wdata;
  end

  assign o_blk      = blocks[i_index];
  assign o_blk_next = blocks[i_index_next];   // upper bytes for offsets 13..15

endmodule

// File: hw/icache_ctrl.sv
////////////////////////////////////////////////////////////
// icache refill controller
// miss detection, stall, memory strobe and array write timing
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module icache_ctrl (
  input  logic                i_riscv_icache_clk,
  input  logic                i_rst_n,
  input  logic                i_hit,
  input  logic                i_hit_next,
  input  icache_pkg::offset_t i_offset,
  input  logic                i_mem_ready,
  output logic                o_stall,
  output logic                o_mem_rd,
  output logic                o_arr_wr,
  output logic                o_blk_sel
);

  import icache_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_nxt;

  logic need_next;   // fetch crosses into the following block
  logic miss;

  assign need_next = i_offset > LAST_IN_BLK_OFF;
  assign miss      = !i_hit || (need_next && !i_hit_next);

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_riscv_icache_clk) begin
    if (!i_rst_n) state <= IDLE;
    else          state <= state_nxt;
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (miss) state_nxt = FILL_REQ;
      end
      FILL_REQ: begin
        state_nxt = FILL_WAIT;        // strobe lasts one cycle
      end
      FILL_WAIT: begin
        if (i_mem_ready) state_nxt = FILL_WR;
      end
      FILL_WR: begin
        state_nxt = ALIGN_CHK;
      end
      ALIGN_CHK: begin
        // second block may still be missing
        state_nxt = miss ? FILL_REQ : IDLE;
      end
      default: state_nxt = IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////

  // stall rises in the same cycle as a missing fetch
  assign o_stall  = (state != IDLE) || miss;
  assign o_mem_rd = (state == FILL_REQ);
  assign o_arr_wr = (state == FILL_WR);

  // current block first, then the next one
  assign o_blk_sel = i_hit && need_next && !i_hit_next;

  // array write exactly one cycle after each memory answer
  a_wr_after_ready : assert property (@(posedge i_riscv_icache_clk) disable iff (!i_rst_n)
    o_arr_wr == $past(i_mem_ready));

endmodule

// File: hw/riscv_instructions_cache.sv
////////////////////////////////////////////////////////////
// riscv instruction cache top level
// direct mapped, 16-byte blocks, unaligned fetch across blocks
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module riscv_instructions_cache #(
  parameter int MEM_LAT = 4
) (
  input  logic               i_riscv_icache_clk,
  input  logic               i_rst_n,
  input  icache_pkg::addr_t  i_addr,
  output icache_pkg::instr_t o_instr,
  output logic               o_stall
);

  import icache_pkg::*;

  fetch_addr_t fa;
  blk_addr_t   blk_cur;
  blk_addr_t   blk_nxt;     // following block, wraps at top of memory
  blk_addr_t   mem_addr;
  tag_t        tag_nxt;
  index_t      index_nxt;

  block_t      blk;
  block_t      blk_next;
  logic [255:0] blk_pair;   // next block above current block

  mem_rsp_t    mem_rsp;
  logic        hit;
  logic        hit_next;
  logic        mem_rd;
  logic        arr_wr;
  logic        blk_sel;

  ////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////

  assign fa                 = fetch_addr_t'(i_addr);
  assign blk_cur            = {fa.tag, fa.index};
  assign blk_nxt            = blk_cur + 1'b1;
  assign {tag_nxt, index_nxt} = blk_nxt;
  assign mem_addr           = blk_sel ? blk_nxt : blk_cur;

  // any offset 0..15, upper bytes come from the next block
  assign blk_pair = {blk_next, blk};
  assign o_instr  = blk_pair[{fa.offset, 3'b000} +: 32];

  ////////////////////////////////////////////////////////////
  // blocks
  ////////////////////////////////////////////////////////////

  icache_refill_mem #(
    .MEM_LAT(MEM_LAT)
  ) u_mem (
    .i_riscv_icache_clk(i_riscv_icache_clk),
    .i_rst_n           (i_rst_n           ),
    .i_rd              (mem_rd            ),
    .i_blk_addr        (mem_addr          ),
    .o_rsp             (mem_rsp           )
  );

  icache_tag_array u_tags (
    .i_riscv_icache_clk(i_riscv_icache_clk),
    .i_rst_n           (i_rst_n           ),
    .i_tag             (fa.tag            ),
    .i_index           (fa.index          ),
    .i_tag_next        (tag_nxt           ),
    .i_index_next      (index_nxt         ),
    .i_wr              (arr_wr            ),
    .i_wr_sel          (blk_sel           ),
    .o_hit             (hit               ),
    .o_hit_next        (hit_next          )
  );

  icache_data_array u_data (
    .i_riscv_icache_clk(i_riscv_icache_clk),
    .i_index           (fa.index          ),
    .i_index_next      (index_nxt         ),
    .i_wr              (arr_wr            ),
    .i_wr_sel          (blk_sel           ),
    .i_wdata           (mem_rsp.data      ),
    .o_blk             (blk               ),
    .o_blk_next        (blk_next          )
  );

  icache_ctrl u_ctrl (
    .i_riscv_icache_clk(i_riscv_icache_clk),
    .i_rst_n           (i_rst_n           ),
    .i_hit             (hit               ),
    .i_hit_next        (hit_next          ),
    .i_offset          (fa.offset         ),
    .i_mem_ready       (mem_rsp.ready     ),
    .o_stall           (o_stall           ),
    .o_mem_rd          (mem_rd            ),
    .o_arr_wr          (arr_wr            ),
    .o_blk_sel         (blk_sel           )
  );

endmodule

// File: tb/tb_riscv_instructions_cache.sv
////////////////////////////////////////////////////////////
// instruction cache testbench
// replays fetches from the stim file, checks stall and data
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_riscv_instructions_cache;

  import icache_pkg::*;

  localparam int    MEM_LAT   = 4;
  localparam string STIM_FILE = "tb/icache_stim.txt";

  logic   clk;
  logic   rst_n;
  addr_t  addr;
  instr_t instr;
  logic   stall;

  // one entry per stim line, reset entries carry no fetch
  logic   stim_reset [$];
  addr_t  stim_addr  [$];
  logic   stim_hit   [$];
  instr_t stim_instr [$];

  int errors      = 0;
  int fetches     = 0;
  int cycle_count = 0;
  int cycle_limit = 0;   // set once the file is read

  riscv_instructions_cache #(
    .MEM_LAT(MEM_LAT)
  ) u_dut (
    .i_riscv_icache_clk(clk  ),
    .i_rst_n           (rst_n),
    .i_addr            (addr ),
    .o_instr           (instr),
    .o_stall           (stall)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;   // 20 ns period

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, the cache never released the stall", cycle_count);
      $display("TB FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic load_stim();
    int          fd;
    int          h;
    string       line;
    string       word;
    logic [15:0] a;
    logic [31:0] ins;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file %s", STIM_FILE);
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        word = "";
        if ($sscanf(line, "%s", word) == 1 && word.substr(0, 0) != "#") begin
          if (word == "reset") begin
            stim_reset.push_back(1'b1);
            stim_addr.push_back('0);
            stim_hit.push_back(1'b0);
            stim_instr.push_back('0);
          end else if ($sscanf(line, "%h %d %h", a, h, ins) == 3) begin
            stim_reset.push_back(1'b0);
            stim_addr.push_back(a);
            stim_hit.push_back(h != 0);
            stim_instr.push_back(ins);
          end else begin
            errors++;
            $display("could not read the stimulus line: %s", line);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // reset stays low until run_fetch drives the next address
  task automatic apply_reset();
    @(posedge clk);
    #2;
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
  endtask

  task automatic run_fetch(input addr_t a, input logic hit, input instr_t exp);
    @(posedge clk);
    #2;
    rst_n = 1'b1;
    addr  = a;
    @(negedge clk);
    check_value(32'(stall), 32'(!hit), $sformatf("stall for fetch %h", a));
    while (stall !== 1'b0) @(negedge clk);   // refill in progress
    check_value(instr, exp, $sformatf("instruction at %h", a));
    fetches++;
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n = 1'b0;
    addr  = '0;
    load_stim();
    if (stim_reset.size() == 0) begin
      errors++;
      $display("no fetches found in %s, nothing was tested", STIM_FILE);
    end else begin
      cycle_limit = 20 * stim_reset.size() * (MEM_LAT + 4);
      repeat (3) @(posedge clk);   // 4th reset cycle ends in run_fetch
      foreach (stim_reset[i]) begin
        if (stim_reset[i]) begin
          apply_reset();
        end else begin
          run_fetch(stim_addr[i], stim_hit[i], stim_instr[i]);
        end
      end
    end
    $display("fetches checked %0d, errors %0d", fetches, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: riscv_instructions_cache.f
hw/icache_pkg.sv
hw/icache_refill_mem.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_ctrl.sv
hw/riscv_instructions_cache.sv
tb/tb_riscv_instructions_cache.sv

// File: Makefile
# Verilator build and run for the instruction cache testbench
TOP := tb_riscv_instructions_cache

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f riscv_instructions_cache.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// File: tb/icache_stim.txt
# columns: fetch address (hex), expected hit (0 or 1), expected instruction (hex)
# a line holding only the word reset pulses reset for 4 cycles
0100 0 02030001
0104 1 06070405
0101 1 05020300
0107 1 0b080906
010c 1 0e0f0c0d
010b 1 0f0c0d0a
0105 1 09060704
0106 1 08090607
0108 1 0a0b0809
010a 1 0c0d0a0b
010d 0 110e0f0c
0112 1 14151213
010e 1 10110e0f
010f 1 1310110e
023e 0 43423d3c
0240 1 41404342
0503 0 03000106
0104 0 06070405
0503 0 03000106
fffd 0 00000102
reset
0240 0 41404342
0240 1 41404342
0249 1 4e49484b
024f 0 5053524d
